//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= overlay_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/overlay_cfg_if.sv
`timescale 1ns/1ps

interface overlay_cfg_if
   import overlay_pkg::*;
();
   logic                  enable;
   logic [OVL_MODE_W-1:0] mode;
   logic [OVL_TIME_W-1:0] hide_after;
   logic                  restart;    // One cycle pulse on CTRL or TIME writes
   logic                  visible;

   modport regs_mp (
      output enable, mode, hide_after, restart,
      input  visible
   );

   modport mixer_mp (
      input  enable, mode, hide_after, restart,
      output visible
   );

endinterface

//--- hdl/overlay_mixer.sv
`timescale 1ns/1ps

module overlay_mixer
   import overlay_pkg::*;
(
   input  logic                vin_clk_i,
   input  logic                rst_ni,
   input  logic                vin_vs_i,
   input  logic                vin_de_i,
   input  logic [23:0]         vin_data_i,
   input  logic [7:0]          pat_byte_i,
   input  logic                pat_valid_i,
   overlay_cfg_if.mixer_mp     cfg,
   output logic                vin_vs_o,
   output logic                vin_de_o,
   output logic [23:0]         vin_data_o
);
   logic [OVL_FETCH_LAT-1:0] vs_d;
   logic [OVL_FETCH_LAT-1:0] de_d;
   logic [23:0]              data_d [OVL_FETCH_LAT];
   logic [OVL_TIME_W-1:0]    frame_q;
   logic                     vs_rise;
   logic                     visible;
   logic                     fold;
   logic [23:0]              pix;

   assign vs_rise = vin_vs_i && !vs_d[0];
   assign visible = cfg.enable && (cfg.hide_after == '0 || frame_q < cfg.hide_after);
   assign cfg.visible = visible;

   assign pix  = data_d[OVL_FETCH_LAT-1];
   assign fold = visible && pat_valid_i && pat_byte_i[cfg.mode];

   always_ff @(posedge vin_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         vs_d     <= '0;
         de_d     <= '0;
         frame_q  <= '0;
         vin_vs_o <= 1'b0;
         vin_de_o <= 1'b0;
      end else begin
         vs_d     <= {vs_d[OVL_FETCH_LAT-2:0], vin_vs_i};
         de_d     <= {de_d[OVL_FETCH_LAT-2:0], vin_de_i};
         vin_vs_o <= vs_d[OVL_FETCH_LAT-1];
         vin_de_o <= de_d[OVL_FETCH_LAT-1];
         if (cfg.restart) begin
            frame_q <= '0;
         end else if (vs_rise && frame_q < cfg.hide_after) begin
            frame_q <= frame_q + 1'b1; // Counts frames up to the hide limit
         end
      end
   end

   always_ff @(posedge vin_clk_i) begin
      data_d[0] <= vin_data_i;
      for (int i = 1; i < OVL_FETCH_LAT; i++) begin
         data_d[i] <= data_d[i-1];
      end
      if (fold) begin
         vin_data_o <= {ovl_fold(pix[23:16]), ovl_fold(pix[15:8]), ovl_fold(pix[7:0])};
      end else begin
         vin_data_o <= pix;
      end
   end

endmodule

//--- hdl/overlay_pattern_fetch.sv
`timescale 1ns/1ps

module overlay_pattern_fetch
   import overlay_pkg::*;
(
   input  logic       vin_clk_i,
   input  logic       rst_ni,
   input  logic       vin_vs_i,
   input  logic       vin_de_i,
   output logic [7:0] pat_byte_o,
   output logic       pat_valid_o
);
   logic [OVL_COL_W-1:0]   col_q;
   logic [OVL_LINE_W-1:0]  line_q;
   logic [OVL_BLK_W-1:0]   blk_q;
   logic                   de_q;
   logic                   in_win;
   logic                   win_q;
   logic                   win_qq;
   logic [OVL_WADDR_W-1:0] waddr_q;
   logic [2:0]             bsel_q;
   logic [2:0]             bsel_qq;
   logic [63:0]            word_q;
   logic [63:0]            rom [OVL_WORDS];

   initial begin
      $readmemh(OVL_ROM_FILE, rom);
   end

   // Current pixel is active and lies inside the fixed window
   assign in_win = vin_de_i && !vin_vs_i &&
                   col_q >= OVL_XMIN && col_q <= OVL_XMAX &&
                   line_q >= OVL_YMIN && line_q <= OVL_YMAX;

   always_ff @(posedge vin_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         col_q  <= '0;
         line_q <= '0;
         blk_q  <= '0;
         de_q   <= 1'b0;
      end else begin
         de_q <= vin_de_i;
         if (vin_vs_i) begin
            col_q  <= '0;
            line_q <= '0;
            blk_q  <= '0;
         end else if (vin_de_i) begin
            if (col_q <= OVL_XMAX) begin
               col_q <= col_q + 1'b1;
            end
            if (in_win) begin
               blk_q <= blk_q + 1'b1;
            end
         end else if (de_q) begin
            // End of an active line
            col_q <= '0;
            if (line_q <= OVL_YMAX) begin
               line_q <= line_q + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge vin_clk_i) begin
      if (in_win) begin
         waddr_q <= blk_q[OVL_BLK_W-1:3];
         bsel_q  <= blk_q[2:0];
      end
      bsel_qq <= bsel_q;
      if (win_q) begin
         word_q <= rom[waddr_q];
      end
   end

   always_ff @(posedge vin_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         win_q       <= 1'b0;
         win_qq      <= 1'b0;
         pat_valid_o <= 1'b0;
         pat_byte_o  <= '0;
      end else begin
         win_q       <= in_win;
         win_qq      <= win_q;
         pat_valid_o <= win_qq;
         // Byte 0 sits in the top bits of the word
         pat_byte_o  <= win_qq ? word_q[8*(7-bsel_qq) +: 8] : 8'h00;
      end
   end

endmodule

//--- hdl/overlay_pkg.sv
package overlay_pkg;

   // Window bounds in pixel columns and lines, both ends inclusive
   localparam int OVL_XMIN = 4;
   localparam int OVL_XMAX = 19;
   localparam int OVL_YMIN = 2;
   localparam int OVL_YMAX = 9;

   localparam int    OVL_BLKS     = 128; // One block per window pixel
   localparam int    OVL_WORDS    = 16;  // 64-bit words of eight pattern bytes
   localparam string OVL_ROM_FILE = "hdl/overlay_rom.mem";

   // Counters stop one past the window edge
   localparam int OVL_COL_W     = $clog2(OVL_XMAX + 2);
   localparam int OVL_LINE_W    = $clog2(OVL_YMAX + 2);
   localparam int OVL_BLK_W     = $clog2(OVL_BLKS);
   localparam int OVL_WADDR_W   = $clog2(OVL_WORDS);
   localparam int OVL_FETCH_LAT = 3; // Input pixel to pattern byte

   localparam int                    OVL_AXI_AW   = 4;
   localparam logic [OVL_AXI_AW-1:0] OVL_REG_CTRL = 4'h0;
   localparam logic [OVL_AXI_AW-1:0] OVL_REG_TIME = 4'h4;
   localparam logic [OVL_AXI_AW-1:0] OVL_REG_STAT = 4'h8;
   localparam int                    OVL_MODE_W   = 3;
   localparam int                    OVL_TIME_W   = 16;

   // Upper half drops by 128 and lower half mirrors around 127
   function automatic logic [7:0] ovl_fold(input logic [7:0] chan);
      if (chan >= 8'd128) begin
         return chan - 8'd128;
      end
      return 8'd127 - chan;
   endfunction

endpackage

//--- hdl/overlay_regs.sv
`timescale 1ns/1ps

module overlay_regs
   import overlay_pkg::*;
(
   input  logic                  vin_clk_i,
   input  logic                  rst_ni,
   input  logic [OVL_AXI_AW-1:0] s_awaddr_i,
   input  logic                  s_awvalid_i,
   output logic                  s_awready_o,
   input  logic [31:0]           s_wdata_i,
   input  logic [3:0]            s_wstrb_i,
   input  logic                  s_wvalid_i,
   output logic                  s_wready_o,
   output logic [1:0]            s_bresp_o,
   output logic                  s_bvalid_o,
   input  logic                  s_bready_i,
   input  logic [OVL_AXI_AW-1:0] s_araddr_i,
   input  logic                  s_arvalid_i,
   output logic                  s_arready_o,
   output logic [31:0]           s_rdata_o,
   output logic [1:0]            s_rresp_o,
   output logic                  s_rvalid_o,
   input  logic                  s_rready_i,
   overlay_cfg_if.regs_mp        cfg
);
   logic                  enable_q;
   logic [OVL_MODE_W-1:0] mode_q;
   logic [OVL_TIME_W-1:0] hide_q;
   logic                  restart_q;
   logic                  busy;
   logic                  wr_go;
   logic                  rd_go;
   logic [31:0]           rd_word;

   // No new transfer while either response is still pending
   assign busy  = s_bvalid_o || s_rvalid_o;
   assign wr_go = s_awvalid_i && s_wvalid_i && !busy;
   assign rd_go = s_arvalid_i && !busy && !wr_go; // A write wins a tie

   assign s_awready_o = wr_go;
   assign s_wready_o  = wr_go;
   assign s_arready_o = rd_go;
   assign s_bresp_o   = 2'b00;
   assign s_rresp_o   = 2'b00;

   always_ff @(posedge vin_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         enable_q   <= 1'b1;
         mode_q     <= '0;
         hide_q     <= '0;
         restart_q  <= 1'b0;
         s_bvalid_o <= 1'b0;
      end else begin
         restart_q <= 1'b0;
         if (s_bvalid_o && s_bready_i) begin
            s_bvalid_o <= 1'b0;
         end
         if (wr_go) begin
            s_bvalid_o <= 1'b1;
            case (s_awaddr_i)
               OVL_REG_CTRL: begin
                  restart_q <= 1'b1;
                  if (s_wstrb_i[0]) begin
                     enable_q <= s_wdata_i[0];
                     mode_q   <= s_wdata_i[4 +: OVL_MODE_W];
                  end
               end
               OVL_REG_TIME: begin
                  restart_q <= 1'b1;
                  for (int b = 0; b < OVL_TIME_W / 8; b++) begin
                     if (s_wstrb_i[b]) begin
                        hide_q[8*b +: 8] <= s_wdata_i[8*b +: 8];
                     end
                  end
               end
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      rd_word = '0; // Unmapped addresses read as zero
      case (s_araddr_i)
         OVL_REG_CTRL: begin
            rd_word[0]               = enable_q;
            rd_word[4 +: OVL_MODE_W] = mode_q;
         end
         OVL_REG_TIME: rd_word[OVL_TIME_W-1:0] = hide_q;
         OVL_REG_STAT: rd_word[0] = cfg.visible;
         default: ;
      endcase
   end

   always_ff @(posedge vin_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         s_rvalid_o <= 1'b0;
      end else if (rd_go) begin
         s_rvalid_o <= 1'b1;
      end else if (s_rready_i) begin
         s_rvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge vin_clk_i) begin
      if (rd_go) begin
         s_rdata_o <= rd_word;
      end
   end

   assign cfg.enable     = enable_q;
   assign cfg.mode       = mode_q;
   assign cfg.hide_after = hide_q;
   assign cfg.restart    = restart_q;

endmodule

//--- hdl/overlay_rom.mem
// One 64-bit word per line, eight pattern bytes each, byte 0 of the word in bits 63:56
00020406080A0C0E
10121416181A1C1E
21232527292B2D2F
31333537393B3D3F
424046444A484E4C
525056545A585E5C
636167656B696F6D
737177757B797F7D
848680828C8E888A
949690929C9E989A
A5A7A1A3ADAFA9AB
B5B7B1B3BDBFB9BB
C6C4C2C0CECCCAC8
D6D4D2D0DEDCDAD8
E7E5E3E1EFEDEBE9
F7F5F3F1FFFDFBF9

//--- hdl/overlay_top.sv
`timescale 1ns/1ps

module overlay_top
   import overlay_pkg::*;
(
   input  logic                  vin_clk_i,
   input  logic                  rst_ni,
   input  logic [OVL_AXI_AW-1:0] s_awaddr_i,
   input  logic                  s_awvalid_i,
   output logic                  s_awready_o,
   input  logic [31:0]           s_wdata_i,
   input  logic [3:0]            s_wstrb_i,
   input  logic                  s_wvalid_i,
   output logic                  s_wready_o,
   output logic [1:0]            s_bresp_o,
   output logic                  s_bvalid_o,
   input  logic                  s_bready_i,
   input  logic [OVL_AXI_AW-1:0] s_araddr_i,
   input  logic                  s_arvalid_i,
   output logic                  s_arready_o,
   output logic [31:0]           s_rdata_o,
   output logic [1:0]            s_rresp_o,
   output logic                  s_rvalid_o,
   input  logic                  s_rready_i,
   input  logic                  vin_vs_i,
   input  logic                  vin_de_i,
   input  logic [23:0]           vin_data_i,
   output logic                  vin_vs_o,
   output logic                  vin_de_o,
   output logic [23:0]           vin_data_o
);
   logic [7:0] pat_byte;
   logic       pat_valid;

   overlay_cfg_if cfg_bus ();

   overlay_regs i_regs (
      .vin_clk_i   (vin_clk_i),
      .rst_ni      (rst_ni),
      .s_awaddr_i  (s_awaddr_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_wdata_i   (s_wdata_i),
      .s_wstrb_i   (s_wstrb_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_bresp_o   (s_bresp_o),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i),
      .s_araddr_i  (s_araddr_i),
      .s_arvalid_i (s_arvalid_i),
      .s_arready_o (s_arready_o),
      .s_rdata_o   (s_rdata_o),
      .s_rresp_o   (s_rresp_o),
      .s_rvalid_o  (s_rvalid_o),
      .s_rready_i  (s_rready_i),
      .cfg         (cfg_bus.regs_mp)
   );

   overlay_pattern_fetch i_fetch (
      .vin_clk_i   (vin_clk_i),
      .rst_ni      (rst_ni),
      .vin_vs_i    (vin_vs_i),
      .vin_de_i    (vin_de_i),
      .pat_byte_o  (pat_byte),
      .pat_valid_o (pat_valid)
   );

   // Pattern byte and pixel meet here three cycles after the input
   overlay_mixer i_mixer (
      .vin_clk_i   (vin_clk_i),
      .rst_ni      (rst_ni),
      .vin_vs_i    (vin_vs_i),
      .vin_de_i    (vin_de_i),
      .vin_data_i  (vin_data_i),
      .pat_byte_i  (pat_byte),
      .pat_valid_i (pat_valid),
      .cfg         (cfg_bus.mixer_mp),
      .vin_vs_o    (vin_vs_o),
      .vin_de_o    (vin_de_o),
      .vin_data_o  (vin_data_o)
   );

endmodule

//--- sources.f
hdl/overlay_pkg.sv
hdl/overlay_cfg_if.sv
hdl/overlay_regs.sv
hdl/overlay_pattern_fetch.sv
hdl/overlay_mixer.sv
hdl/overlay_top.sv
verification/tb_clk_gen.sv
verification/overlay_checker.sv
verification/overlay_tb.sv

//--- verification/overlay_checker.sv
`timescale 1ns/1ps

module overlay_checker
   import overlay_pkg::*;
(
   input logic                  vin_clk_i,
   input logic                  rst_ni,
   input logic [OVL_AXI_AW-1:0] awaddr_i,
   input logic [OVL_AXI_AW-1:0] araddr_i,
   input logic                  awvalid_i, awready_i, wvalid_i, wready_i,
   input logic                  bvalid_i, bready_i, arvalid_i, arready_i,
   input logic                  rvalid_i, rready_i,
   input logic [31:0]           wdata_i,
   input logic [31:0]           rdata_i,
   input logic [3:0]            wstrb_i,
   input logic [1:0]            bresp_i,
   input logic [1:0]            rresp_i,
   input logic                  vs_in_i, de_in_i, vs_out_i, de_out_i,
   input logic [23:0]           data_in_i,
   input logic [23:0]           data_out_i
);
   logic [63:0]           rom [OVL_WORDS];
   logic [26:0]           pipe [4]; // Valid, vs, de and pixel as they should leave the DUT
   logic                  enable_m;
   logic [OVL_MODE_W-1:0] mode_m;
   logic [OVL_TIME_W-1:0] hide_m;
   logic [OVL_TIME_W-1:0] frames;
   logic                  vs_prev;
   logic                  de_prev;
   logic [31:0]           rd_exp;
   int                    col;
   int                    row;
   int                    checks = 0, errors = 0, sync_checks = 0, sync_errs = 0;
   int                    tests = 0, base_checks = 0, base_errs = 0;

   initial begin
      $readmemh(OVL_ROM_FILE, rom);
   end

   // Values from 128 up lose their top bit, lower values become 127 minus the value
   function automatic logic [7:0] fold_ref(input logic [7:0] c);
      return c[7] ? {1'b0, c[6:0]} : {1'b0, ~c[6:0]};
   endfunction

   function automatic logic shown();
      return enable_m && (hide_m == '0 || frames < hide_m);
   endfunction

   function automatic logic [23:0] expect_pixel(input logic [23:0] pix, input logic act,
                                                input int c, input int r,
                                                input logic [OVL_MODE_W-1:0] m,
                                                input logic vis);
      logic [6:0]  blk;
      logic [63:0] word;
      logic [7:0]  pat;
      if (!act || !vis || c < OVL_XMIN || c > OVL_XMAX || r < OVL_YMIN || r > OVL_YMAX) begin
         return pix;
      end
      blk  = 7'((r - OVL_YMIN) * (OVL_XMAX - OVL_XMIN + 1) + (c - OVL_XMIN));
      word = rom[blk[6:3]] << {blk[2:0], 3'b000}; // Bring the block's byte to the top
      pat  = word[63:56];
      if (!pat[m]) begin
         return pix;
      end
      return {fold_ref(pix[23:16]), fold_ref(pix[15:8]), fold_ref(pix[7:0])};
   endfunction

   always @(negedge vin_clk_i) begin
      if (!rst_ni) begin
         enable_m = 1'b1;
         mode_m   = '0;
         hide_m   = '0;
         frames   = '0;
         vs_prev  = 1'b0;
         de_prev  = 1'b0;
         rd_exp   = '0;
         col      = 0;
         row      = 0;
         for (int i = 0; i < 4; i++) begin
            pipe[i] = '0;
         end
      end else begin
         if (pipe[3][26]) begin
            sync_checks++;
            if ({vs_out_i, de_out_i} !== pipe[3][25:24]) begin
               $display("MISMATCH vin_vs_o/vin_de_o: got %h/%h, expected %h/%h",
                        vs_out_i, de_out_i, pipe[3][25], pipe[3][24]);
               sync_errs++;
               errors++;
            end
            if (pipe[3][24]) begin
               checks++;
               if (data_out_i !== pipe[3][23:0]) begin
                  $display("MISMATCH vin_data_o: got %h, expected %h", data_out_i, pipe[3][23:0]);
                  errors++;
               end
            end
         end
         if (awready_i !== wready_i || (bvalid_i && (awready_i || arready_i))) begin
            $display("AXI handshake error: ready signals wrong while a response was pending");
            errors++;
         end
         if (bvalid_i && bready_i && bresp_i !== 2'b00) begin
            $display("MISMATCH s_bresp_o: got %h, expected %h", bresp_i, 2'b00);
            errors++;
         end
         if (rvalid_i && rready_i) begin
            checks++;
            if (rdata_i !== rd_exp || rresp_i !== 2'b00) begin
               $display("MISMATCH s_rdata_o: got %h, expected %h (s_rresp_o %h)",
                        rdata_i, rd_exp, rresp_i);
               errors++;
            end
         end
         if (arvalid_i && arready_i) begin
            case (araddr_i)
               OVL_REG_CTRL: rd_exp = {25'd0, mode_m, 3'd0, enable_m};
               OVL_REG_TIME: rd_exp = {16'd0, hide_m};
               OVL_REG_STAT: rd_exp = {31'd0, shown()};
               default:      rd_exp = '0;
            endcase
         end
         if (awvalid_i && wvalid_i && awready_i) begin
            if (awaddr_i == OVL_REG_CTRL || awaddr_i == OVL_REG_TIME) begin
               frames = '0; // Any control or time write starts the hide timer again
            end
            if (awaddr_i == OVL_REG_CTRL && wstrb_i[0]) begin
               enable_m = wdata_i[0];
               mode_m   = wdata_i[6:4];
            end
            if (awaddr_i == OVL_REG_TIME && wstrb_i[0]) begin
               hide_m[7:0] = wdata_i[7:0];
            end
            if (awaddr_i == OVL_REG_TIME && wstrb_i[1]) begin
               hide_m[15:8] = wdata_i[15:8];
            end
         end
         if (vs_in_i && !vs_prev && frames < hide_m) begin
            frames = frames + 1'b1;
         end
         for (int i = 3; i > 0; i--) begin
            pipe[i] = pipe[i-1];
         end
         pipe[0] = {1'b1, vs_in_i, de_in_i,
                    expect_pixel(data_in_i, de_in_i && !vs_in_i, col, row, mode_m, shown())};
         if (vs_in_i) begin
            col = 0;
            row = 0;
         end else if (de_in_i) begin
            col++;
         end else if (de_prev) begin
            col = 0; // Falling edge of data enable ends the line
            row++;
         end
         vs_prev = vs_in_i;
         de_prev = de_in_i;
      end
   end

   task automatic end_test(input string name);
      tests++;
      $display("%s: %0d checks, %0d errors", name, checks - base_checks, errors - base_errs);
      base_checks = checks;
      base_errs   = errors;
   endtask

   task automatic report_totals();
      tests++;
      $display("[6] output sync delay: %0d checks, %0d errors", sync_checks, sync_errs);
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks + sync_checks, errors);
   endtask

endmodule

//--- verification/overlay_tb.sv
`timescale 1ns/1ps

module overlay_tb
   import overlay_pkg::*;
();
   localparam int CLK_NS      = 4;
   localparam int SEED        = 19520;
   localparam int VS_CYC      = 3;
   localparam int LINES       = 12;
   localparam int PIXELS      = 24;
   localparam int BLANK       = 4;
   localparam int FRAME_CYC   = VS_CYC + LINES * (PIXELS + BLANK);
   localparam int TEST_FRAMES = 14; // Frames sent by tests 1 to 5 together

   logic                  clk, rst_n;
   logic [OVL_AXI_AW-1:0] awaddr, araddr;
   logic                  awvalid, awready, wvalid, wready, bvalid, bready;
   logic                  arvalid, arready, rvalid, rready;
   logic [31:0]           wdata, rdata;
   logic [3:0]            wstrb;
   logic [1:0]            bresp, rresp;
   logic                  vs_in, de_in, vs_out, de_out;
   logic [23:0]           data_in, data_out;

   tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(2)) i_clk_gen (
      .clk_o  (clk),
      .rst_no (rst_n)
   );

   overlay_top i_overlay_top (
      .vin_clk_i   (clk),
      .rst_ni      (rst_n),
      .s_awaddr_i  (awaddr),
      .s_awvalid_i (awvalid),
      .s_awready_o (awready),
      .s_wdata_i   (wdata),
      .s_wstrb_i   (wstrb),
      .s_wvalid_i  (wvalid),
      .s_wready_o  (wready),
      .s_bresp_o   (bresp),
      .s_bvalid_o  (bvalid),
      .s_bready_i  (bready),
      .s_araddr_i  (araddr),
      .s_arvalid_i (arvalid),
      .s_arready_o (arready),
      .s_rdata_o   (rdata),
      .s_rresp_o   (rresp),
      .s_rvalid_o  (rvalid),
      .s_rready_i  (rready),
      .vin_vs_i    (vs_in),
      .vin_de_i    (de_in),
      .vin_data_i  (data_in),
      .vin_vs_o    (vs_out),
      .vin_de_o    (de_out),
      .vin_data_o  (data_out)
   );

   overlay_checker i_checker (
      .vin_clk_i (clk), .rst_ni (rst_n),
      .awaddr_i (awaddr), .araddr_i (araddr),
      .awvalid_i (awvalid), .awready_i (awready), .wvalid_i (wvalid), .wready_i (wready),
      .bvalid_i (bvalid), .bready_i (bready), .arvalid_i (arvalid), .arready_i (arready),
      .rvalid_i (rvalid), .rready_i (rready),
      .wdata_i (wdata), .rdata_i (rdata), .wstrb_i (wstrb),
      .bresp_i (bresp), .rresp_i (rresp),
      .vs_in_i (vs_in), .de_in_i (de_in), .vs_out_i (vs_out), .de_out_i (de_out),
      .data_in_i (data_in), .data_out_i (data_out)
   );

   task automatic axi_write(input logic [OVL_AXI_AW-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int bready_delay);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= strb;
      wvalid  <= 1'b1;
      @(negedge clk);
      while (!awready) begin
         @(negedge clk);
      end
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      repeat (bready_delay) @(posedge clk); // Response left waiting on purpose
      bready <= 1'b1;
      @(negedge clk);
      while (!(bvalid && bready)) begin
         @(negedge clk);
      end
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [OVL_AXI_AW-1:0] addr);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      @(negedge clk);
      while (!arready) begin
         @(negedge clk);
      end
      @(posedge clk);
      arvalid <= 1'b0;
      @(negedge clk);
      while (!rvalid) begin
         @(negedge clk);
      end
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic send_frame();
      logic [31:0] rnd;
      repeat (VS_CYC) begin
         @(posedge clk);
         vs_in   <= 1'b1;
         de_in   <= 1'b0;
         data_in <= '0;
      end
      for (int l = 0; l < LINES; l++) begin
         for (int p = 0; p < PIXELS + BLANK; p++) begin
            rnd = $urandom;
            @(posedge clk);
            vs_in   <= 1'b0;
            de_in   <= (p < PIXELS);
            data_in <= (p < PIXELS) ? rnd[23:0] : 24'h0;
         end
      end
   endtask

   initial begin
      #(TEST_FRAMES * FRAME_CYC * CLK_NS * 2);
      $display("Timeout: test sequence still running after %0d ns",
               TEST_FRAMES * FRAME_CYC * CLK_NS * 2);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
      {araddr, arvalid, rready} = '0;
      {vs_in, de_in, data_in} = '0;
      wait (rst_n == 1'b1);

      send_frame();
      send_frame();
      i_checker.end_test("[1] reset defaults, mode 0");

      for (int m = 1; m < 8; m++) begin
         axi_write(OVL_REG_CTRL, {25'd0, 3'(m), 4'h1}, 4'h1, 0);
         send_frame();
      end
      i_checker.end_test("[2] modes 1 to 7");

      axi_write(OVL_REG_CTRL, 32'h0, 4'h1, 0);
      send_frame();
      axi_read(OVL_REG_STAT);
      i_checker.end_test("[3] overlay disabled");

      axi_write(OVL_REG_CTRL, 32'h31, 4'h1, 0);
      axi_write(OVL_REG_TIME, 32'h2, 4'h3, 0);
      axi_read(OVL_REG_STAT);
      repeat (3) send_frame();
      axi_read(OVL_REG_STAT);
      i_checker.end_test("[4] hide after two frames");

      axi_write(OVL_REG_TIME, 32'h0, 4'h3, 0);
      axi_read(OVL_REG_CTRL);
      axi_read(OVL_REG_TIME);
      axi_read(4'hC);
      // The read request waits behind the write until its late response is taken
      fork
         axi_write(OVL_REG_CTRL, 32'h51, 4'h1, 6);
         axi_read(OVL_REG_CTRL);
      join
      send_frame();
      i_checker.end_test("[5] register readback and late bready");

      repeat (8) @(posedge clk);
      i_checker.report_totals();
      if (i_checker.errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 4,
   parameter int RST_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_no
);
   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_no = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_no <= 1'b1; // Released on a rising edge
   end

endmodule
